//--- common/odelay_pkg.sv
`default_nettype none

package odelay_pkg;

    // Number of delay lanes in the bank.
    localparam int unsigned num_lanes = 8;

    // Width of a lane index.
    localparam int unsigned lane_idx_w = 3;

    // Delay word split.
    // Coarse count in the upper bits, fine count in the lower bits.
    localparam int unsigned coarse_w = 5;
    localparam int unsigned fine_w = 3;

    // Tap index width, wide enough for the full history depth.
    localparam int unsigned tap_w = 8;

    // Largest legal fine count, as in the vendor primitive.
    localparam logic [fine_w-1:0] fine_max = 3'd4;

    // Cycles that one coarse step is worth in the behavioral model.
    localparam logic [tap_w-1:0] fine_per_coarse = 8'd5;

    // Longest delay, 31 coarse and 4 fine.
    localparam int unsigned max_delay = 159;

    // Coarse and fine view of a delay word.
    typedef struct packed {
        logic [coarse_w-1:0] coarse;
        logic [fine_w-1:0]   fine;
    } delay_fields_t;

    // Same byte seen raw (ports, host side) or as fields (lanes).
    typedef union packed {
        logic [coarse_w+fine_w-1:0] raw;
        delay_fields_t              f;
    } delay_word_t;

    // Host write: strobe, target lane and new delay word.
    typedef struct packed {
        logic                  wr;
        logic [lane_idx_w-1:0] lane;
        delay_word_t           value;
    } odelay_wr_t;

    // Word taken by every lane at reset.
    // Coarse 2, fine 3, so 13 cycles.
    localparam delay_word_t reset_delay = 8'b00010_011;

endpackage

`default_nettype wire

//--- src/odelay_tap_line.sv
`timescale 1ns/10ps
`default_nettype none

module odelay_tap_line (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [odelay_pkg::coarse_w-1:0] coarse,
    input  logic [odelay_pkg::fine_w-1:0]   fine,
    input  logic                          din,
    output logic                          dout
);

    // Sample history of din.
    // Bit 0 is the value taken at the last edge, bit j is j edges older.
    logic [odelay_pkg::max_delay:0] hist;

    // Fine count clipped to the legal range.
    logic [odelay_pkg::fine_w-1:0] fine_sat;

    // Counts widened to the tap index width.
    logic [odelay_pkg::tap_w-1:0] coarse_ext;
    logic [odelay_pkg::tap_w-1:0] fine_ext;

    // Selected history position.
    logic [odelay_pkg::tap_w-1:0] tap;

    // The primitive never adds more than fine_max steps.
    // Keeps the tap inside the history for any coarse value.
    assign fine_sat = (fine > odelay_pkg::fine_max) ? odelay_pkg::fine_max : fine;

    assign coarse_ext = {{(odelay_pkg::tap_w - odelay_pkg::coarse_w){1'b0}}, coarse};
    assign fine_ext   = {{(odelay_pkg::tap_w - odelay_pkg::fine_w){1'b0}}, fine_sat};

    // Five cycles per coarse step plus one per fine step.
    assign tap = coarse_ext * odelay_pkg::fine_per_coarse + fine_ext;

    // Shift in din every cycle, including across delay changes.
    // A new delay just reads another point of the same history.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist <= '0;
        end else begin
            hist <= {hist[odelay_pkg::max_delay-1:0], din};
        end
    end

    // Tap zero is din registered once.
    // Any delay D therefore shows up D+1 edges after din.
    assign dout = hist[tap];

endmodule

`default_nettype wire

//--- src/odelay_fine_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module odelay_fine_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ld,
    input  logic                    apply,
    input  odelay_pkg::delay_word_t delay,
    input  logic                    din,
    output logic                    dout
);

    // Word waiting for the next apply.
    odelay_pkg::delay_word_t staged;

    // Word currently steering the tap line.
    odelay_pkg::delay_word_t active;

    // Staging register, loaded by this lane's strobe.
    // Coarse and fine both go through it.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            staged <= odelay_pkg::reset_delay;
        end else if (ld) begin
            staged <= delay;
        end
    end

    // Active register.
    // Apply is common to all lanes, so every lane switches on the same edge.
    // A load in the same cycle is not seen until the next apply.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= odelay_pkg::reset_delay;
        end else if (apply) begin
            active <= staged;
        end
    end

    // Behavioral model of the vendor delay element.
    odelay_tap_line u_tap_line (
        .clk    (clk),
        .rst    (rst),
        .coarse (active.f.coarse),
        .fine   (active.f.fine),
        .din    (din),
        .dout   (dout)
    );

    // Staged fine count must stay legal before it can ever be applied.
    // Catches a bad word arriving from the lane select one cycle later.
    a_staged_fine_legal: assert property (
        @(posedge clk) disable iff (rst)
        staged.f.fine <= odelay_pkg::fine_max
    ) else $error("staged fine count %0d above limit", staged.f.fine);

endmodule

`default_nettype wire

//--- odelay_bank/odelay_lane_select.sv
`timescale 1ns/10ps
`default_nettype none

module odelay_lane_select (
    input  logic                                clk,
    input  logic                                rst,
    input  odelay_pkg::odelay_wr_t              cfg,
    output logic [odelay_pkg::num_lanes-1:0]    ld,
    output odelay_pkg::delay_word_t             delay
);

    // Write held for one cycle.
    odelay_pkg::odelay_wr_t cfg_q;

    // One write accepted per cycle, never stalled.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_q <= '0;
        end else begin
            cfg_q <= cfg;
        end
    end

    // Lane index to one-hot load strobe.
    // Zero when no write was taken.
    always_comb begin
        ld = '0;
        if (cfg_q.wr) begin
            ld[cfg_q.lane] = 1'b1;
        end
    end

    // One word for all lanes, only the strobed lane keeps it.
    assign delay = cfg_q.value;

    // A strobe addresses at most one lane.
    a_ld_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(ld)
    ) else $error("load strobe %b addresses more than one lane", ld);

    // Host must not write a fine count the primitive cannot take.
    a_fine_legal: assert property (
        @(posedge clk) disable iff (rst)
        cfg.wr |-> (cfg.value.f.fine <= odelay_pkg::fine_max)
    ) else $error("write to lane %0d with fine count %0d",
                  cfg.lane, cfg.value.f.fine);

endmodule

`default_nettype wire

//--- odelay_bank/odelay_bank.sv
`timescale 1ns/10ps
`default_nettype none

module odelay_bank (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [odelay_pkg::num_lanes-1:0] ld,
    input  logic                             apply,
    input  odelay_pkg::delay_word_t          delay,
    input  logic [odelay_pkg::num_lanes-1:0] din,
    output logic [odelay_pkg::num_lanes-1:0] dout
);

    // One lane per data bit.
    // Shared word and apply, private load strobe.
    for (genvar i = 0; i < odelay_pkg::num_lanes; i++) begin : g_lane
        odelay_fine_pipe u_lane (
            .clk   (clk),
            .rst   (rst),
            .ld    (ld[i]),
            .apply (apply),
            .delay (delay),
            .din   (din[i]),
            .dout  (dout[i])
        );
    end

    // Apply is a single-cycle strobe.
    // Two in a row would mean a stuck or misdriven host line.
    a_apply_strobe: assert property (
        @(posedge clk) disable iff (rst)
        apply |=> !apply
    ) else $error("apply held high for more than one cycle");

endmodule

`default_nettype wire

//--- src/odelay_top.sv
`timescale 1ns/10ps
`default_nettype none

module odelay_top (
    input  logic                             clk,
    input  logic                             rst,
    input  odelay_pkg::odelay_wr_t           cfg,
    input  logic                             apply,
    input  logic [odelay_pkg::num_lanes-1:0] din,
    output logic [odelay_pkg::num_lanes-1:0] dout
);

    // Decoded load strobes, one per lane.
    logic [odelay_pkg::num_lanes-1:0] ld;

    // Word written by the host, one cycle late.
    odelay_pkg::delay_word_t delay;

    // Write register and lane decode.
    odelay_lane_select u_lane_select (
        .clk   (clk),
        .rst   (rst),
        .cfg   (cfg),
        .ld    (ld),
        .delay (delay)
    );

    // Delay lanes.
    odelay_bank u_bank (
        .clk   (clk),
        .rst   (rst),
        .ld    (ld),
        .apply (apply),
        .delay (delay),
        .din   (din),
        .dout  (dout)
    );

endmodule

`default_nettype wire

//--- test/odelay_tb.sv
`timescale 1ns/10ps
`default_nettype none

module odelay_tb;

    // Clock period in ns.
    localparam int period = 8;
    localparam int rst_cycles = 16;

    // Run lengths after a delay change, long enough for the old taps to age out.
    localparam int settle_short = 40;
    localparam int settle_long = 200;
    localparam int hold_cycles = 30;

    // Upper bound on the cycles each test takes.
    localparam int t1_cycles = settle_short + 4;
    localparam int t2_cycles = settle_short + 10;
    localparam int t3_cycles = hold_cycles + settle_short + 10;
    localparam int t4_cycles = 2 * settle_short + 12;
    localparam int t5_cycles = settle_long + 16;
    localparam int margin_cycles = 100;
    localparam int total_cycles = rst_cycles + t1_cycles + t2_cycles + t3_cycles
                                + t4_cycles + t5_cycles + margin_cycles;

    logic                             clk;
    logic                             rst;
    odelay_pkg::odelay_wr_t           cfg;
    logic                             apply;
    logic [odelay_pkg::num_lanes-1:0] din;
    logic [odelay_pkg::num_lanes-1:0] dout;

    integer seed = 32'hc342f9b6;

    // Model of the lanes, kept from the strobe timing rules.
    odelay_pkg::delay_word_t        staged_m [odelay_pkg::num_lanes];
    odelay_pkg::delay_word_t        active_m [odelay_pkg::num_lanes];
    logic [odelay_pkg::max_delay:0] hist_m   [odelay_pkg::num_lanes];

    // Write held in the lane select for one cycle.
    logic                              pend_wr;
    logic [odelay_pkg::lane_idx_w-1:0] pend_lane;
    odelay_pkg::delay_word_t           pend_val;

    // Edges seen since reset, saturated at the history depth.
    int samples;

    int checks = 0;
    int mismatches = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_start_mm = 0;

    odelay_top DUT (
        .clk   (clk),
        .rst   (rst),
        .cfg   (cfg),
        .apply (apply),
        .din   (din),
        .dout  (dout)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Fresh random data on every lane each cycle.
    always @(posedge clk) begin
        din <= odelay_pkg::num_lanes'($random(seed));
    end

    // Expected output bit of one lane.
    // Delay is five cycles per coarse step plus the fine count.
    function automatic logic expected_dout(input odelay_pkg::delay_word_t w,
                                           input logic [odelay_pkg::max_delay:0] h);
        int d;
        d = int'(w.f.coarse) * 5 + int'(w.f.fine);
        // History before reset reads as zero.
        if (samples < d + 1) begin
            return 1'b0;
        end
        return h[d];
    endfunction

    function automatic odelay_pkg::delay_word_t make_word(input int coarse, input int fine);
        odelay_pkg::delay_word_t w;
        w.f.coarse = odelay_pkg::coarse_w'(coarse);
        w.f.fine = odelay_pkg::fine_w'(fine);
        return w;
    endfunction

    // Any legal word, fine count 0 to 4.
    function automatic odelay_pkg::delay_word_t random_word();
        odelay_pkg::delay_word_t w;
        w.f.coarse = odelay_pkg::coarse_w'($unsigned($random(seed)) % 32);
        w.f.fine = odelay_pkg::fine_w'($unsigned($random(seed)) % 5);
        return w;
    endfunction

    // Model update, on the same values the DUT samples at this edge.
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < odelay_pkg::num_lanes; i++) begin
                staged_m[i] = odelay_pkg::reset_delay;
                active_m[i] = odelay_pkg::reset_delay;
                hist_m[i] = '0;
            end
            pend_wr = 1'b0;
            pend_lane = '0;
            pend_val = '0;
            samples = 0;
        end else begin
            // Apply takes the staged words from before this edge.
            if (apply) begin
                for (int i = 0; i < odelay_pkg::num_lanes; i++) begin
                    active_m[i] = staged_m[i];
                end
            end
            // Last cycle's write reaches its lane now.
            if (pend_wr) begin
                staged_m[pend_lane] = pend_val;
            end
            pend_wr = cfg.wr;
            pend_lane = cfg.lane;
            pend_val = cfg.value;
            for (int i = 0; i < odelay_pkg::num_lanes; i++) begin
                hist_m[i] = {hist_m[i][odelay_pkg::max_delay-1:0], din[i]};
            end
            if (samples <= odelay_pkg::max_delay) begin
                samples++;
            end
        end
    end

    // Compare every lane at the falling edge, when dout is settled.
    always @(negedge clk) begin : compare
        logic exp_bit;
        if (!rst) begin
            for (int i = 0; i < odelay_pkg::num_lanes; i++) begin
                exp_bit = expected_dout(active_m[i], hist_m[i]);
                checks++;
                assert (dout[i] === exp_bit) else begin
                    $display("Error at %0t ns: dout[%0d] expected %b, got %b",
                             $time, i, exp_bit, dout[i]);
                    mismatches++;
                end
            end
        end
    end

    // One cycle of host activity.
    task automatic drive_cycle(input logic wr, input int lane, input logic [7:0] raw,
                               input logic ap);
        odelay_pkg::odelay_wr_t c;
        @(posedge clk);
        c.wr = wr;
        c.lane = odelay_pkg::lane_idx_w'(lane);
        c.value.raw = raw;
        cfg <= c;
        apply <= ap;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(1'b0, 0, 8'h00, 1'b0);
    endtask

    task automatic write_lane(input int lane, input odelay_pkg::delay_word_t w);
        drive_cycle(1'b1, lane, w.raw, 1'b0);
    endtask

    task automatic apply_all();
        drive_cycle(1'b0, 0, 8'h00, 1'b1);
    endtask

    // Report one test, counting the mismatches seen since the previous one.
    task automatic finish_test(input int num, input string name);
        int mm;
        @(negedge clk);
        #1;
        mm = mismatches - test_start_mm;
        tests_run++;
        if (mm == 0) begin
            $display("Test %0d (%s) ok", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d (%s) failed with %0d mismatches", num, name, mm);
        end
        test_start_mm = mismatches;
    endtask

    initial begin : main
        odelay_pkg::delay_word_t w;
        rst = 1'b1;
        cfg = '0;
        apply = 1'b0;
        din = '0;
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;

        // Reset word on every lane, zeros until history fills.
        idle(settle_short);
        finish_test(1, "reset delay");

        // One lane moves to 4 cycles, the rest stay at 13.
        write_lane(3, make_word(0, 4));
        idle(2);
        apply_all();
        idle(settle_short);
        finish_test(2, "single lane write and apply");

        // Staged only, output keeps the old delay until apply.
        write_lane(5, make_word(7, 1));
        idle(hold_cycles);
        apply_all();
        idle(settle_short);
        finish_test(3, "write held until apply");

        // Last staged word wins. The write issued with apply waits for the next one.
        write_lane(1, make_word(3, 2));
        write_lane(1, make_word(9, 0));
        write_lane(1, make_word(6, 4));
        idle(1);
        w = make_word(1, 1);
        drive_cycle(1'b1, 1, w.raw, 1'b1);
        idle(settle_short);
        apply_all();
        idle(settle_short);
        finish_test(4, "last write wins");

        // All lanes at once, with the shortest and longest delay.
        write_lane(0, make_word(0, 0));
        write_lane(1, make_word(31, 4));
        for (int i = 2; i < odelay_pkg::num_lanes; i++) begin
            write_lane(i, random_word());
        end
        idle(2);
        apply_all();
        idle(settle_long);
        finish_test(5, "all lanes in one apply");

        $display("Tests run %0d, failed %0d; checks %0d, mismatches %0d",
                 tests_run, tests_failed, checks, mismatches);
        if (tests_failed == 0 && mismatches == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Ends a stuck run.
    initial begin : watchdog
        #(total_cycles * period);
        $display("Timeout: the run did not finish within %0d cycles", total_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
common/odelay_pkg.sv
src/odelay_tap_line.sv
src/odelay_fine_pipe.sv
odelay_bank/odelay_lane_select.sv
odelay_bank/odelay_bank.sv
src/odelay_top.sv
test/odelay_tb.sv

//--- Bender.yml
package:
  name: odelay

sources:
  - common/odelay_pkg.sv
  - src/odelay_tap_line.sv
  - src/odelay_fine_pipe.sv
  - odelay_bank/odelay_lane_select.sv
  - odelay_bank/odelay_bank.sv
  - src/odelay_top.sv
  - target: test
    files:
      - test/odelay_tb.sv
